// File: build.f
+incdir+include
logic/bpuPkg.sv
logic/pairTable.sv
logic/factTable.sv
logic/pastTable.sv
logic/returnStack.sv
logic/nextPcSelect.sv
logic/branchUnit.sv
verif/branchUnitTb.sv

// File: include/bpu_defs_defs.svh
// branch predictor sizing: address, table hash, history and counter widths
`ifndef BPU_DEFS_DEFS_SVH
`define BPU_DEFS_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// address and table geometry
//////////////////////////////////////////////////////////////////////
`define ADDR_WIDTH 32                                   // instruction address
`define HASH_DEPTH 5                                    // index bits, 32 entries
`define HASH_WIDTH (`ADDR_WIDTH - 3 - `HASH_DEPTH)      // tag above pair offset + index

// return address stack entries
`define RAS_DEPTH 8

//////////////////////////////////////////////////////////////////////
// local history and pattern counters
//////////////////////////////////////////////////////////////////////
`define HIST_WIDTH 2                                    // per-slot local history
`define CNT_WIDTH  2                                    // saturating counter

`endif

// File: logic/bpuPkg.sv
// branch predictor package: address, slot type and table entry types
`default_nettype none
`include "bpu_defs_defs.svh"

package bpuPkg;

    typedef logic [`ADDR_WIDTH-1:0] addrT;
    typedef logic [`HASH_WIDTH-1:0] tagT;
    typedef logic [`HASH_DEPTH-1:0] indexT;

    // slot kind as sent by decode and execute
    typedef enum logic [1:0] {
        none = 2'd0,
        cond = 2'd1,                    // conditional branch
        jump = 2'd2,                    // direct jump
        ret  = 2'd3                     // return, target from stack
    } instTypeE;

    typedef struct packed {
        instTypeE kind;
        addrT     target;
    } factSlotT;

    typedef struct packed {
        factSlotT upper;                // pc bit 2 set
        factSlotT lower;
    } factEntryT;

    // one counter per history value
    typedef struct packed {
        logic                                          trained;
        logic [`HIST_WIDTH-1:0]                        hist;
        logic [2**`HIST_WIDTH-1:0][`CNT_WIDTH-1:0]     cnt;
    } pastSlotT;

    typedef struct packed {
        pastSlotT upper;
        pastSlotT lower;
    } pastEntryT;

    // pair index sits just above the 8-byte offset
    function automatic indexT pcIndex(addrT pc);
        return pc[3 +: `HASH_DEPTH];
    endfunction

    function automatic tagT pcTag(addrT pc);
        return pc[`ADDR_WIDTH-1 -: `HASH_WIDTH];
    endfunction

endpackage

`default_nettype wire

// File: logic/branchUnit.sv
// branch prediction unit top: fact and past lookup, return stack, next-PC selection
`timescale 1ns/10ps
`default_nettype none

module branchUnit import bpuPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     ifVld,             // lookup strobe
    input  addrT     ifPC,
    input  logic     idVld,             // decode strobe
    input  addrT     idPC,
    input  instTypeE idType1,
    input  instTypeE idType2,
    input  addrT     idTarget1,
    input  addrT     idTarget2,
    input  logic     exVld,             // execute strobe
    input  addrT     exPC,
    input  instTypeE exType,
    input  logic     exBranch,
    input  logic     exWrong,           // flushes the return stack
    input  logic     push,              // call seen by the core
    input  addrT     pcStack,
    output logic     pdVld,
    output addrT     pdPC,
    output logic     pdBranch,
    output logic     pdReason,
    output logic     pdKnown1,
    output logic     pdKnown2,
    output addrT     pdTarget1,
    output addrT     pdTarget2
);

    logic      erVld;
    addrT      erPC;
    logic      factHit;
    factEntryT factEntry;
    pastEntryT pastEntry;
    logic      rasEmpty;
    logic      rasPop;
    addrT      rasTop;

    //////////////////////////////////////////////////////////////////////
    // lookup stage
    //////////////////////////////////////////////////////////////////////
    factTable u_fact (
        .clk       (clk),
        .arstN     (arstN),
        .idVld     (idVld),
        .idPC      (idPC),
        .idType1   (idType1),
        .idType2   (idType2),
        .idTarget1 (idTarget1),
        .idTarget2 (idTarget2),
        .ifVld     (ifVld),
        .ifPC      (ifPC),
        .erVld     (erVld),
        .erPC      (erPC),
        .ifHit     (factHit),
        .ifFact    (factEntry)
    );

    pastTable u_past (
        .clk      (clk),
        .arstN    (arstN),
        .erVld    (erVld),
        .erPC     (erPC),
        .exVld    (exVld),
        .exPC     (exPC),
        .exType   (exType),
        .exBranch (exBranch),
        .ifVld    (ifVld),
        .ifPC     (ifPC),
        .ifPast   (pastEntry)
    );

    returnStack u_ras (
        .clk      (clk),
        .arstN    (arstN),
        .push     (push),
        .pushAddr (pcStack),
        .pop      (rasPop),
        .clear    (exWrong),
        .empty    (rasEmpty),
        .top      (rasTop)
    );

    //////////////////////////////////////////////////////////////////////
    // selection stage
    //////////////////////////////////////////////////////////////////////
    nextPcSelect u_select (
        .clk       (clk),
        .arstN     (arstN),
        .ifVld     (ifVld),
        .ifPC      (ifPC),
        .factHit   (factHit),
        .fact      (factEntry),
        .past      (pastEntry),
        .rasEmpty  (rasEmpty),
        .rasTop    (rasTop),
        .rasPop    (rasPop),
        .pdVld     (pdVld),
        .pdPC      (pdPC),
        .pdBranch  (pdBranch),
        .pdReason  (pdReason),
        .pdKnown1  (pdKnown1),
        .pdKnown2  (pdKnown2),
        .pdTarget1 (pdTarget1),
        .pdTarget2 (pdTarget2)
    );

endmodule

`default_nettype wire

// File: logic/factTable.sv
// fact table: learns branch kinds and targets of each instruction pair from decode
`timescale 1ns/10ps
`default_nettype none

module factTable import bpuPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      idVld,
    input  addrT      idPC,
    input  instTypeE  idType1,
    input  instTypeE  idType2,
    input  addrT      idTarget1,
    input  addrT      idTarget2,
    input  logic      ifVld,
    input  addrT      ifPC,
    output logic      erVld,            // entry replaced this cycle
    output addrT      erPC,
    output logic      ifHit,
    output factEntryT ifFact
);

    factEntryT wrEntry;
    logic      tableVld;
    tagT       tableTag;
    tagT       lookTag;                 // tag of the lookup in flight

    //////////////////////////////////////////////////////////////////////
    // decode side
    //////////////////////////////////////////////////////////////////////
    assign wrEntry = '{
        lower: '{kind: idType1, target: idTarget1},
        upper: '{kind: idType2, target: idTarget2}
    };

    // replacement event, past table clears the same index
    assign erVld = idVld;
    assign erPC  = idPC;

    pairTable #(
        .entryT (factEntryT)
    ) u_table (
        .clk     (clk),
        .arstN   (arstN),
        .wrEn    (idVld),
        .wrIndex (pcIndex(idPC)),
        .wrTag   (pcTag(idPC)),
        .wrData  (wrEntry),
        .rdEn    (ifVld),
        .rdIndex (pcIndex(ifPC)),
        .rdHit   (tableVld),
        .rdTag   (tableTag),
        .rdData  (ifFact)
    );

    //////////////////////////////////////////////////////////////////////
    // fetch side
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (ifVld)
            lookTag <= pcTag(ifPC);     // lines up with registered read
    end

    assign ifHit = tableVld && (tableTag == lookTag);

endmodule

`default_nettype wire

// File: logic/nextPcSelect.sv
// next-PC selection: picks the first taken slot of the looked-up pair
`timescale 1ns/10ps
`default_nettype none
`include "bpu_defs_defs.svh"

module nextPcSelect import bpuPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      ifVld,
    input  addrT      ifPC,
    input  logic      factHit,
    input  factEntryT fact,
    input  pastEntryT past,
    input  logic      rasEmpty,
    input  addrT      rasTop,
    output logic      rasPop,
    output logic      pdVld,
    output addrT      pdPC,
    output logic      pdBranch,
    output logic      pdReason,         // 0 lower slot, 1 upper slot
    output logic      pdKnown1,
    output logic      pdKnown2,
    output addrT      pdTarget1,
    output addrT      pdTarget2
);

    logic     vldQ;
    addrT     pcQ;
    addrT     pairPC;                   // aligned pair address
    logic     take1;
    logic     take2;
    factSlotT winSlot;

    // same stage as the table reads
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            vldQ <= 1'b0;
        else
            vldQ <= ifVld;
    end

    always_ff @(posedge clk) begin
        if (ifVld)
            pcQ <= ifPC;
    end

    // taken decision for one slot
    function automatic logic slotTaken(factSlotT f, pastSlotT p, addrT slotPC,
                                       logic stackEmpty);
        logic taken;
        case (f.kind)
            jump:    taken = 1'b1;
            ret:     taken = !stackEmpty;
            cond:    taken = p.trained ? (p.cnt[p.hist] >= 2'd2)
                                       : (f.target < slotPC);  // backward rule
            default: taken = 1'b0;
        endcase
        return taken;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // slot qualification
    //////////////////////////////////////////////////////////////////////
    assign pairPC   = {pcQ[`ADDR_WIDTH-1:3], 3'b000};
    // fetch into the upper half skips the lower slot
    assign pdKnown1 = factHit && (fact.lower.kind != none) && !pcQ[2];
    assign pdKnown2 = factHit && (fact.upper.kind != none);

    assign take1 = pdKnown1 && slotTaken(fact.lower, past.lower, pairPC, rasEmpty);
    assign take2 = pdKnown2 && slotTaken(fact.upper, past.upper, pairPC | 'd4, rasEmpty);

    //////////////////////////////////////////////////////////////////////
    // prediction
    //////////////////////////////////////////////////////////////////////
    assign winSlot  = take1 ? fact.lower : fact.upper;   // lower first
    assign pdVld    = vldQ;
    assign pdBranch = take1 || take2;
    assign pdReason = !take1 && take2;

    always_comb begin
        if (!pdBranch)
            pdPC = pairPC + 'd8;        // fall through to next pair
        else if (winSlot.kind == ret)
            pdPC = rasTop;
        else
            pdPC = winSlot.target;
    end

    // consume the stack top only on a real prediction
    assign rasPop = vldQ && pdBranch && (winSlot.kind == ret);

    assign pdTarget1 = factHit ? fact.lower.target : '0;
    assign pdTarget2 = factHit ? fact.upper.target : '0;

endmodule

`default_nettype wire

// File: logic/pairTable.sv
// direct-mapped tagged pair table, one write port and one registered read port
`timescale 1ns/10ps
`default_nettype none

module pairTable import bpuPkg::*; #(
    parameter type entryT = logic
) (
    input  logic  clk,
    input  logic  arstN,
    input  logic  wrEn,
    input  indexT wrIndex,
    input  tagT   wrTag,
    input  entryT wrData,
    input  logic  rdEn,
    input  indexT rdIndex,
    output logic  rdHit,                // entry valid at read time
    output tagT   rdTag,
    output entryT rdData
);

    localparam int entries = 1 << $bits(indexT);

    logic [entries-1:0] vldBits;
    tagT                tagArr  [entries];
    entryT              dataArr [entries];

    // valid bits and read hit
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            vldBits <= '0;
            rdHit   <= 1'b0;
        end else begin
            if (wrEn)
                vldBits[wrIndex] <= 1'b1;
            if (rdEn)
                rdHit <= vldBits[rdIndex];  // old value on same-cycle write
        end
    end

    // tag and payload storage
    always_ff @(posedge clk) begin
        if (wrEn) begin
            tagArr[wrIndex]  <= wrTag;
            dataArr[wrIndex] <= wrData;
        end
        if (rdEn) begin
            rdTag  <= tagArr[rdIndex];
            rdData <= dataArr[rdIndex];
        end
    end

endmodule

`default_nettype wire

// File: logic/pastTable.sv
// past table: per-slot local history and pattern counters trained from execute
`timescale 1ns/10ps
`default_nettype none
`include "bpu_defs_defs.svh"

module pastTable import bpuPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      erVld,
    input  addrT      erPC,
    input  logic      exVld,
    input  addrT      exPC,
    input  instTypeE  exType,
    input  logic      exBranch,
    input  logic      ifVld,
    input  addrT      ifPC,
    output pastEntryT ifPast
);

    localparam int entries = 1 << $bits(indexT);
    // untrained, history 0, counters weakly not-taken
    localparam pastSlotT slotInit = '{trained: 1'b0, hist: '0, cnt: '{default: 1}};

    indexT     exIdx;
    indexT     erIdx;
    logic      exHit;
    logic      tableVld;
    tagT       tableTag;
    tagT       lookTag;
    logic      freshQ;                  // lookup index was re-decoded
    pastEntryT tableData;
    pastEntryT curEntry;
    pastEntryT updEntry;
    pastSlotT  curSlot;
    pastSlotT  newSlot;
    logic [`CNT_WIDTH-1:0] cntNow;

    logic [entries-1:0] shadowVld;
    logic [entries-1:0] fresh;
    tagT                shadowTag [entries];
    pastEntryT          mirror    [entries];  // copy for the read-modify-write

    assign exIdx = pcIndex(exPC);
    assign erIdx = pcIndex(erPC);
    // cond only and only for the pair that decode last put at this index
    assign exHit = exVld && (exType == cond) && shadowVld[exIdx]
                   && (shadowTag[exIdx] == pcTag(exPC));

    //////////////////////////////////////////////////////////////////////
    // counter and history update
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        curEntry = mirror[exIdx];
        curSlot  = exPC[2] ? curEntry.upper : curEntry.lower;
        newSlot  = curSlot;
        cntNow   = curSlot.cnt[curSlot.hist];
        if (exBranch && cntNow != '1)
            cntNow = cntNow + 1'b1;     // saturate high
        else if (!exBranch && cntNow != '0)
            cntNow = cntNow - 1'b1;     // saturate low
        newSlot.cnt[curSlot.hist] = cntNow;
        newSlot.hist    = {curSlot.hist[`HIST_WIDTH-2:0], exBranch};
        newSlot.trained = 1'b1;
        updEntry = curEntry;
        if (exPC[2])
            updEntry.upper = newSlot;
        else
            updEntry.lower = newSlot;
    end

    // decode writes last and wins on the same index
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            shadowVld <= '0;
            fresh     <= '0;
            freshQ    <= 1'b0;
        end else begin
            if (exHit)
                fresh[exIdx] <= 1'b0;
            if (erVld) begin
                shadowVld[erIdx] <= 1'b1;
                fresh[erIdx]     <= 1'b1;
            end
            if (ifVld)
                freshQ <= fresh[pcIndex(ifPC)];
        end
    end

    always_ff @(posedge clk) begin
        if (exHit)
            mirror[exIdx] <= updEntry;
        if (erVld) begin
            mirror[erIdx]    <= {slotInit, slotInit};
            shadowTag[erIdx] <= pcTag(erPC);
        end
        if (ifVld)
            lookTag <= pcTag(ifPC);
    end

    // lookup copy written by execute only
    pairTable #(
        .entryT (pastEntryT)
    ) u_table (
        .clk     (clk),
        .arstN   (arstN),
        .wrEn    (exHit),
        .wrIndex (exIdx),
        .wrTag   (pcTag(exPC)),
        .wrData  (updEntry),
        .rdEn    (ifVld),
        .rdIndex (pcIndex(ifPC)),
        .rdHit   (tableVld),
        .rdTag   (tableTag),
        .rdData  (tableData)
    );

    // initial values when never trained or reset by decode since
    assign ifPast = (tableVld && tableTag == lookTag && !freshQ) ? tableData
                                                                 : {slotInit, slotInit};

endmodule

`default_nettype wire

// File: logic/returnStack.sv
// return address stack: circular buffer with push, pop and clear
`timescale 1ns/10ps
`default_nettype none
`include "bpu_defs_defs.svh"

module returnStack import bpuPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic push,
    input  addrT pushAddr,
    input  logic pop,
    input  logic clear,                 // mispredict flush, beats push and pop
    output logic empty,
    output addrT top
);

    localparam int depth = `RAS_DEPTH;
    localparam int ptrW  = $clog2(depth);
    localparam int cntW  = $clog2(depth + 1);

    logic [ptrW-1:0] topPtr;
    logic [cntW-1:0] count;
    logic            replace;           // push and pop together
    addrT            stackMem [depth];

    assign replace = push && pop && (count != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            topPtr <= '0;
            count  <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (replace) begin
            // top overwritten in place
        end else if (push) begin
            topPtr <= topPtr + 1'b1;
            if (count != cntW'(depth))
                count <= count + 1'b1;  // full: oldest slot is reused
        end else if (pop && count != '0) begin
            topPtr <= topPtr - 1'b1;
            count  <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!clear && push) begin
            if (replace)
                stackMem[topPtr] <= pushAddr;
            else
                stackMem[topPtr + 1'b1] <= pushAddr;
        end
    end

    assign empty = (count == '0);
    assign top   = stackMem[topPtr];

endmodule

`default_nettype wire

// File: verif/branchUnitTb.sv
// branch unit testbench: directed and random traffic against a reference model
`timescale 1ns/10ps
`default_nettype none
`include "bpu_defs_defs.svh"

module branchUnitTb import bpuPkg::*; ();

    localparam int randCycles     = 4000;
    localparam int directedCycles = 400;      // upper bound for the directed phases
    localparam int maxCycles      = 5 + directedCycles + randCycles + 100;
    localparam int entries        = 1 << `HASH_DEPTH;

    typedef struct packed {
        logic branch;
        logic reason;
        logic known1;
        logic known2;
        logic popRet;                         // taken return pops the stack
        addrT pc;
        addrT tgt1;
        addrT tgt2;
    } predT;

    logic clk, arstN, ifVld, idVld, exVld, exBranch, exWrong, push;
    addrT ifPC, idPC, idTarget1, idTarget2, exPC, pcStack;
    instTypeE idType1, idType2, exType;
    logic pdVld, pdBranch, pdReason, pdKnown1, pdKnown2;
    addrT pdPC, pdTarget1, pdTarget2;

    // reference state
    logic      factValid [entries];
    tagT       factTag   [entries];
    factEntryT factMem   [entries];
    pastEntryT pastMem   [entries];
    addrT      stackQ    [$];
    logic      pendVld, pendHit, popFlag;
    addrT      pendPC;
    factEntryT pendFact;
    pastEntryT pendPast;
    int        cycles;

    branchUnit u_branchUnit (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference functions
    //////////////////////////////////////////////////////////////////////
    function automatic indexT idxOf(addrT pc);
        return pc[3 +: `HASH_DEPTH];          // pair index above 8-byte offset
    endfunction

    function automatic tagT tagOf(addrT pc);
        return pc >> (3 + `HASH_DEPTH);
    endfunction

    function automatic pastSlotT freshSlot();
        pastSlotT s;
        s.trained = 1'b0;
        s.hist    = '0;
        for (int k = 0; k < 4; k++)
            s.cnt[k] = 2'd1;
        return s;
    endfunction

    function automatic logic slotTakes(factSlotT f, pastSlotT p, addrT slotPC, logic stkEmpty);
        logic t;
        case (f.kind)
            jump:    t = 1'b1;
            ret:     t = !stkEmpty;
            cond:    t = p.trained ? (p.cnt[p.hist] >= 2'd2) : (f.target < slotPC);
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    // expected pd outputs for one lookup
    function automatic predT predict(addrT pc, logic hit, factEntryT f, pastEntryT p,
                                     logic stkEmpty, addrT stkTop);
        predT r;
        addrT pair;
        r    = '0;
        pair = pc & ~addrT'(7);
        r.known1 = hit && (f.lower.kind != none) && !pc[2];
        r.known2 = hit && (f.upper.kind != none);
        r.pc     = pair + 8;                  // fall-through
        if (r.known1 && slotTakes(f.lower, p.lower, pair, stkEmpty)) begin
            r.branch = 1'b1;
            r.popRet = (f.lower.kind == ret);
            r.pc     = r.popRet ? stkTop : f.lower.target;
        end else if (r.known2 && slotTakes(f.upper, p.upper, pair + 4, stkEmpty)) begin
            r.branch = 1'b1;
            r.reason = 1'b1;
            r.popRet = (f.upper.kind == ret);
            r.pc     = r.popRet ? stkTop : f.upper.target;
        end
        if (hit) begin
            r.tgt1 = f.lower.target;
            r.tgt2 = f.upper.target;
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic checkAddr(string name, addrT exp, addrT act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkFlag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // model update at the sampling edge
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : model
        indexT    ei;
        pastSlotT s;
        logic [1:0] c;
        if (!arstN) begin
            for (int i = 0; i < entries; i++)
                factValid[i] = 1'b0;
            stackQ.delete();
            pendVld = 1'b0;
            popFlag = 1'b0;
        end else begin
            // lookup sees contents before this edge's writes
            pendVld  = ifVld;
            pendPC   = ifPC;
            pendHit  = factValid[idxOf(ifPC)] && (factTag[idxOf(ifPC)] == tagOf(ifPC));
            pendFact = factMem[idxOf(ifPC)];
            pendPast = pastMem[idxOf(ifPC)];
            ei = idxOf(exPC);
            if (exVld && exType == cond && factValid[ei] && factTag[ei] == tagOf(exPC)) begin
                s = exPC[2] ? pastMem[ei].upper : pastMem[ei].lower;
                c = s.cnt[s.hist];
                if (exBranch)
                    c = (c == 2'd3) ? c : c + 1'b1;
                else
                    c = (c == 2'd0) ? c : c - 1'b1;
                s.cnt[s.hist] = c;
                s.hist    = {s.hist[0], exBranch};
                s.trained = 1'b1;
                if (exPC[2])
                    pastMem[ei].upper = s;
                else
                    pastMem[ei].lower = s;
            end
            if (idVld) begin                  // decode after execute so decode wins
                factValid[idxOf(idPC)]          = 1'b1;
                factTag[idxOf(idPC)]            = tagOf(idPC);
                factMem[idxOf(idPC)].lower.kind   = idType1;
                factMem[idxOf(idPC)].lower.target = idTarget1;
                factMem[idxOf(idPC)].upper.kind   = idType2;
                factMem[idxOf(idPC)].upper.target = idTarget2;
                pastMem[idxOf(idPC)]            = {freshSlot(), freshSlot()};
            end
            if (exWrong)
                stackQ.delete();
            else if (push && popFlag && stackQ.size() != 0)
                stackQ[stackQ.size()-1] = pcStack;    // replace top
            else if (push) begin
                if (stackQ.size() == `RAS_DEPTH)
                    void'(stackQ.pop_front());      // oldest lost
                stackQ.push_back(pcStack);
            end else if (popFlag && stackQ.size() != 0)
                void'(stackQ.pop_back());
            popFlag = 1'b0;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin : compare
        predT exp;
        addrT top;
        if (arstN) begin
            top = (stackQ.size() != 0) ? stackQ[stackQ.size()-1] : '0;
            checkFlag("pdVld", pendVld, pdVld);
            if (pendVld) begin
                exp = predict(pendPC, pendHit, pendFact, pendPast, stackQ.size() == 0, top);
                checkFlag("pdBranch", exp.branch, pdBranch);
                checkFlag("pdReason", exp.reason, pdReason);
                checkFlag("pdKnown1", exp.known1, pdKnown1);
                checkFlag("pdKnown2", exp.known2, pdKnown2);
                checkAddr("pdPC", exp.pc, pdPC);
                checkAddr("pdTarget1", exp.tgt1, pdTarget1);
                checkAddr("pdTarget2", exp.tgt2, pdTarget2);
                popFlag = exp.popRet;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > maxCycles) begin
            $display("TEST FAIL");
            $fatal(1, "timeout, run went past %0d cycles", maxCycles);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////
    task automatic quiet();
        ifVld   <= 1'b0;
        idVld   <= 1'b0;
        exVld   <= 1'b0;
        push    <= 1'b0;
        exWrong <= 1'b0;
    endtask

    task automatic lookup(addrT pc);
        @(posedge clk);
        quiet();
        ifVld <= 1'b1;
        ifPC  <= pc;
    endtask

    task automatic decode(addrT pc, instTypeE t1, addrT tg1, instTypeE t2, addrT tg2);
        @(posedge clk);
        quiet();
        idVld     <= 1'b1;
        idPC      <= pc;
        idType1   <= t1;
        idTarget1 <= tg1;
        idType2   <= t2;
        idTarget2 <= tg2;
    endtask

    task automatic execute(addrT pc, logic taken);
        @(posedge clk);
        quiet();
        exVld    <= 1'b1;
        exPC     <= pc;
        exType   <= cond;
        exBranch <= taken;
    endtask

    task automatic call(addrT ra);
        @(posedge clk);
        quiet();
        push    <= 1'b1;
        pcStack <= ra;
    endtask

    task automatic flush();
        @(posedge clk);
        quiet();
        exWrong <= 1'b1;
    endtask

    // two tags over four indexes make hits and tag clashes common
    function automatic addrT randPC();
        return ($urandom_range(1) ? 32'h0000_4000 : 32'h0001_8000)
               | ($urandom_range(3) << 3) | ($urandom_range(1) << 2);
    endfunction

    function automatic addrT randTarget();
        return addrT'($urandom_range(32'h0002_0000)) & ~addrT'(3);
    endfunction

    task automatic randomCycle();
        @(posedge clk);
        quiet();
        ifVld <= ($urandom_range(3) != 0);
        ifPC  <= randPC();
        if ($urandom_range(7) == 0) begin
            idVld     <= 1'b1;
            idPC      <= randPC();
            idType1   <= instTypeE'($urandom_range(3));
            idType2   <= instTypeE'($urandom_range(3));
            idTarget1 <= randTarget();
            idTarget2 <= randTarget();
        end
        exVld    <= ($urandom_range(2) == 0);
        exPC     <= randPC();
        exType   <= ($urandom_range(3) != 0) ? cond : instTypeE'($urandom_range(3));
        exBranch <= $urandom_range(1);
        push     <= ($urandom_range(9) == 0);
        pcStack  <= randTarget();
        exWrong  <= ($urandom_range(63) == 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'hf6845778));
        arstN     = 1'b0;
        ifVld     = 1'b0;
        idVld     = 1'b0;
        exVld     = 1'b0;
        push      = 1'b0;
        exWrong   = 1'b0;
        exBranch  = 1'b0;
        ifPC      = '0;
        idPC      = '0;
        idTarget1 = '0;
        idTarget2 = '0;
        exPC      = '0;
        pcStack   = '0;
        idType1   = none;
        idType2   = none;
        exType    = none;
        cycles    = 0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;

        // miss path on empty tables
        for (int i = 0; i < 6; i++)
            lookup(randPC());
        // slot order and upper-half fetch
        decode(32'h0000_4010, cond, 32'h0000_4050, jump, 32'h0000_5000);
        decode(32'h0000_4018, jump, 32'h0000_6000, jump, 32'h0000_7000);
        lookup(32'h0000_4010);
        lookup(32'h0000_4014);
        lookup(32'h0000_4018);
        lookup(32'h0000_401c);                // lower jump skipped
        lookup(32'h0001_8010);                // same index, other tag
        // conditional learning with backward lower and forward upper
        decode(32'h0000_4020, cond, 32'h0000_4000, cond, 32'h0000_4100);
        lookup(32'h0000_4020);
        for (int i = 0; i < 40; i++) begin
            execute(32'h0000_4020 | ($urandom_range(1) << 2), $urandom_range(1));
            lookup(32'h0000_4020);
        end
        for (int i = 0; i < 6; i++)
            execute(32'h0000_4020, 1'b0);     // lower slot ends strongly not-taken
        lookup(32'h0000_4020);
        decode(32'h0000_4020, cond, 32'h0000_4000, cond, 32'h0000_4100);
        lookup(32'h0000_4020);                // backward rule again after re-decode
        for (int i = 0; i < 4; i++)
            execute(32'h0001_8020, 1'b0);     // other tag leaves the entry untrained
        lookup(32'h0000_4020);
        // return stack empty case, lifo order, overflow and flush
        decode(32'h0000_4028, ret, 32'h0, none, 32'h0);
        lookup(32'h0000_4028);
        for (int i = 0; i < 3; i++)
            call(32'h0000_9000 + 16 * i);
        repeat (4) lookup(32'h0000_4028);
        for (int i = 0; i < 10; i++)
            call(32'h0000_a000 + 16 * i);
        repeat (9) lookup(32'h0000_4028);
        call(32'h0000_b000);
        call(32'h0000_b010);
        flush();
        lookup(32'h0000_4028);
        // mixed traffic
        for (int i = 0; i < randCycles; i++)
            randomCycle();
        repeat (3) begin
            @(posedge clk);
            quiet();
        end
        @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
